// File: tb.f
+incdir+include
src/kem_pkg.sv
src/hash_buffer_ram.sv
src/hash_msg_packer.sv
src/shake_feeder.sv
src/key_store.sv
src/kem_session_key.sv
verif/shake_model.sv
verif/tb_kem_session_key.sv

// File: run_sim.sh
#!/bin/sh
# build and run the session key testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   -f tb.f --top-module tb_kem_session_key -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

if echo "$out" | grep -q "Simulation finished: PASS"; then
   exit 0
fi
exit 1

// File: verif/tb_kem_session_key.sv
`timescale 1ns/1ps
`include "kem_config.svh"

module tb_kem_session_key;

   import kem_pkg::*;

   localparam int STREAM_LEN  = 139;
   localparam int N_GROUPS    = 4;
   // two runs of about 600 cycles each under random ready with a wide margin
   localparam int CYCLE_LIMIT = 5 * 600;

   logic                   clk = 1'b0;
   logic                   rst;
   logic                   start;
   logic                   e_rd;
   logic [`KEM_E_AW-1:0]   e_addr;
   kem_word_t              e_word = '0;
   logic                   c_rd;
   logic [`KEM_C_AW-1:0]   c_addr;
   kem_word_t              c_word = '0;
   logic                   shake_din_valid;
   kem_word_t              shake_din;
   logic                   shake_din_ready;
   logic                   shake_dout_ready;
   logic                   shake_dout_valid;
   kem_word_t              shake_dout;
   logic                   k_rd;
   logic [`KEM_KEY_AW-1:0] k_addr;
   kem_word_t              k_word;
   logic                   done;

   integer               seed;
   int                   model_seed;
   kem_word_t            e_mem [`KEM_E_WORDS];
   kem_word_t            c_mem [`KEM_C_WORDS];
   kem_word_t            exp_stream [STREAM_LEN];
   kem_word_t            out_words [`KEM_KEY_WORDS];
   logic [`KEM_E_AW-1:0] e_addr_q;
   logic [`KEM_C_AW-1:0] c_addr_q;
   logic                 e_rd_q;
   logic                 c_rd_q;

   // captured on the rising edge, checked on the falling edge
   logic      started;
   logic      xfer_seen;
   kem_word_t xfer_word;
   kem_word_t xfer_exp;
   int        xfer_idx;
   int        stream_idx;
   int        cap_cnt;
   int        done_cnt;
   logic      kread_q;
   kem_word_t kexp_q;
   int        cycles = 0;
   int        assert_errs = 0;
   int        task_errs = 0;
   int        tests_run = 0;
   int        tests_failed = 0;

   always #2 clk = ~clk;

   kem_session_key u_kem_session_key (
      .clk              (clk),
      .rst              (rst),
      .start            (start),
      .e_rd             (e_rd),
      .e_addr           (e_addr),
      .e_word           (e_word),
      .c_rd             (c_rd),
      .c_addr           (c_addr),
      .c_word           (c_word),
      .shake_din_valid  (shake_din_valid),
      .shake_din        (shake_din),
      .shake_din_ready  (shake_din_ready),
      .shake_dout_ready (shake_dout_ready),
      .shake_dout_valid (shake_dout_valid),
      .shake_dout       (shake_dout),
      .k_rd             (k_rd),
      .k_addr           (k_addr),
      .k_word           (k_word),
      .done             (done)
   );

   shake_model u_shake (
      .clk        (clk),
      .rst        (rst),
      .seed_base  (model_seed),
      .din_valid  (shake_din_valid),
      .din        (shake_din),
      .din_ready  (shake_din_ready),
      .dout_ready (shake_dout_ready),
      .dout_valid (shake_dout_valid),
      .dout       (shake_dout)
   );

   function automatic kem_word_t swap_bytes(input kem_word_t w);
      kem_word_t r;
      for (int b = 0; b < 4; b++) begin
         r[8*b +: 8] = w[8*(3-b) +: 8];
      end
      return r;
   endfunction

   // memories answer one cycle after the read strobe
   always @(negedge clk) begin
      if (e_rd_q) begin
         e_word <= e_mem[e_addr_q];
      end
      if (c_rd_q) begin
         c_word <= c_mem[c_addr_q];
      end
   end

   always @(posedge clk) begin
      e_rd_q    <= e_rd;
      c_rd_q    <= c_rd;
      e_addr_q  <= e_addr;
      c_addr_q  <= c_addr;
      kread_q   <= k_rd;
      kexp_q    <= swap_bytes(out_words[k_addr]);
      xfer_seen <= shake_din_valid && shake_din_ready;
      if (rst || start) begin
         stream_idx <= 0;
         cap_cnt    <= 0;
         done_cnt   <= 0;
         started    <= start;
      end else begin
         if (shake_din_valid && shake_din_ready) begin
            xfer_word  <= shake_din;
            xfer_exp   <= (stream_idx < STREAM_LEN) ? exp_stream[stream_idx] : '0;
            xfer_idx   <= stream_idx;
            stream_idx <= stream_idx + 1;
         end
         if (shake_dout_valid && shake_dout_ready) begin
            cap_cnt <= cap_cnt + 1;
            if (cap_cnt < `KEM_KEY_WORDS) begin
               out_words[cap_cnt] <= shake_dout;
            end
         end
         if (done) begin
            done_cnt <= done_cnt + 1;
         end
      end
   end

   idle_before_start: assert property (@(negedge clk) disable iff (rst)
      !started |-> !(e_rd || c_rd || shake_din_valid || shake_dout_ready || done))
      else begin
         assert_errs++;
         $display("%0t: a strobe or valid was high before the first start", $time);
      end

   stream_word: assert property (@(negedge clk) disable iff (rst)
      xfer_seen |-> (xfer_word == xfer_exp))
      else begin
         assert_errs++;
         $display("error at %0t: shake_din word %0d got %h expected %h",
                  $time, xfer_idx, xfer_word, xfer_exp);
      end

   stream_length: assert property (@(negedge clk) disable iff (rst)
      xfer_seen |-> (xfer_idx < STREAM_LEN))
      else begin
         assert_errs++;
         $display("%0t: the stream went on past %0d words", $time, STREAM_LEN);
      end

   done_after_key: assert property (@(negedge clk) disable iff (rst)
      done |-> (cap_cnt == `KEM_KEY_WORDS && !shake_dout_ready))
      else begin
         assert_errs++;
         $display("%0t: done came with %0d words taken or with ready still high",
                  $time, cap_cnt);
      end

   key_word: assert property (@(negedge clk) disable iff (rst)
      kread_q |-> (k_word == kexp_q))
      else begin
         assert_errs++;
         $display("error at %0t: k_word got %h expected %h", $time, k_word, kexp_q);
      end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         $display("timeout: the run did not end within %0d cycles", CYCLE_LIMIT);
         $display("Simulation finished: FAIL");
         $finish;
      end
   end

   task automatic fill_memories();
      for (int i = 0; i < `KEM_E_WORDS; i++) begin
         e_mem[i] = $random(seed);
      end
      for (int i = 0; i < `KEM_C_WORDS; i++) begin
         c_mem[i] = $random(seed);
      end
   endtask

   // prefix byte, error bytes msb first, then ciphertext bytes
   task automatic build_expected();
      logic [7:0] msg [4*`KEM_MSG_WORDS];
      int         n;
      for (int i = 0; i < 4*`KEM_MSG_WORDS; i++) begin
         msg[i] = 8'h00;
      end
      msg[0] = 8'h01;
      n = 1;
      for (int i = 0; i < `KEM_E_WORDS; i++) begin
         for (int b = 3; b >= 0; b--) begin
            msg[n] = e_mem[i][8*b +: 8];
            n++;
         end
      end
      for (int i = 0; i < `KEM_C_WORDS; i++) begin
         for (int b = 3; b >= 0; b--) begin
            msg[n] = c_mem[i][8*b +: 8];
            n++;
         end
      end
      exp_stream[0] = `KEM_SHAKE_START;
      n = 1;
      for (int g = 0; g < N_GROUPS; g++) begin
         exp_stream[n] = (g == N_GROUPS - 1) ? `KEM_SHAKE_LAST : `KEM_SHAKE_FULL;
         n++;
         for (int j = g*`KEM_RATE_WORDS;
              j < (g+1)*`KEM_RATE_WORDS && j < `KEM_MSG_WORDS; j++) begin
            exp_stream[n] = {msg[4*j+3], msg[4*j+2], msg[4*j+1], msg[4*j]};
            n++;
         end
      end
   endtask

   task automatic report_test(input string name, input int errs_at_start);
      tests_run++;
      if (assert_errs + task_errs == errs_at_start) begin
         $display("test %s: ok", name);
      end else begin
         tests_failed++;
         $display("test %s: failed", name);
      end
   endtask

   task automatic run_session(input string name, input int run_no);
      int errs_at_start;
      errs_at_start = assert_errs + task_errs;
      fill_memories();
      build_expected();
      start = 1'b1;
      @(negedge clk);
      start = 1'b0;
      while (!done) begin
         @(negedge clk);
      end
      for (int i = 0; i < `KEM_KEY_WORDS; i++) begin
         k_rd   = 1'b1;
         k_addr = i[`KEM_KEY_AW-1:0];
         @(negedge clk);
      end
      k_rd = 1'b0;
      repeat (2) @(negedge clk);
      assert (stream_idx == STREAM_LEN && done_cnt == 1 &&
              u_shake.in_log.size() == run_no * STREAM_LEN)
      else begin
         task_errs++;
         $display("%0t: run ended with %0d stream words and %0d done pulses",
                  $time, stream_idx, done_cnt);
      end
      report_test(name, errs_at_start);
   endtask

   initial begin
      int errs_at_start;
      seed       = 37;
      model_seed = $random(seed);
      rst        = 1'b1;
      start      = 1'b0;
      k_rd       = 1'b0;
      k_addr     = '0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      errs_at_start = assert_errs + task_errs;
      repeat (5) @(negedge clk);
      report_test("idle after reset", errs_at_start);

      run_session("first session key", 1);
      run_session("second session key", 2);

      $display("tests %0d, failed %0d, check errors %0d",
               tests_run, tests_failed, assert_errs + task_errs);
      if (tests_failed == 0 && assert_errs + task_errs == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

// File: verif/shake_model.sv
`timescale 1ns/1ps

module shake_model (
   input  logic               clk,
   input  logic               rst,
   input  int                 seed_base,
   input  logic               din_valid,
   input  kem_pkg::kem_word_t din,
   output logic               din_ready,
   input  logic               dout_ready,
   output logic               dout_valid,
   output kem_pkg::kem_word_t dout
);

   import kem_pkg::*;

   int        seed;
   logic      out_sent;
   kem_word_t in_log [$];

   initial begin
      din_ready  = 1'b0;
      dout_valid = 1'b0;
      dout       = '0;
      out_sent   = 1'b0;
   end

   // words move on the rising edge
   always @(posedge clk) begin
      out_sent <= dout_valid && dout_ready;
      if (din_valid && din_ready) begin
         in_log.push_back(din);
      end
   end

   // roughly one cycle in four without ready or valid
   always @(negedge clk) begin
      if (rst) begin
         seed       = seed_base;
         din_ready  = 1'b0;
         dout_valid = 1'b0;
         dout       = '0;
      end else begin
         din_ready = ($random(seed) & 3) != 0;
         // offered word stays put until it is taken
         if (out_sent || !dout_valid) begin
            dout_valid = ($random(seed) & 3) != 0;
            dout       = $random(seed);
         end
      end
   end

endmodule

// File: src/kem_session_key.sv
`timescale 1ns/1ps
`include "kem_config.svh"

module kem_session_key (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   start,
   output logic                   e_rd,
   output logic [`KEM_E_AW-1:0]   e_addr,
   input  kem_pkg::kem_word_t     e_word,
   output logic                   c_rd,
   output logic [`KEM_C_AW-1:0]   c_addr,
   input  kem_pkg::kem_word_t     c_word,
   output logic                   shake_din_valid,
   output kem_pkg::kem_word_t     shake_din,
   input  logic                   shake_din_ready,
   output logic                   shake_dout_ready,
   input  logic                   shake_dout_valid,
   input  kem_pkg::kem_word_t     shake_dout,
   input  logic                   k_rd,
   input  logic [`KEM_KEY_AW-1:0] k_addr,
   output kem_pkg::kem_word_t     k_word,
   output logic                   done
);

   import kem_pkg::*;

   logic                   buf_we;
   logic [`KEM_BUF_AW-1:0] buf_waddr;
   kem_word_t              buf_wdata;
   logic [`KEM_BUF_AW-1:0] buf_raddr;
   kem_word_t              buf_rdata;
   logic                   msg_ready;
   logic                   stream_done;

   hash_msg_packer u_packer (
      .clk       (clk),
      .rst       (rst),
      .start     (start),
      .e_rd      (e_rd),
      .e_addr    (e_addr),
      .e_word    (e_word),
      .c_rd      (c_rd),
      .c_addr    (c_addr),
      .c_word    (c_word),
      .buf_we    (buf_we),
      .buf_waddr (buf_waddr),
      .buf_wdata (buf_wdata),
      .msg_ready (msg_ready)
   );

   hash_buffer_ram u_hash_buf (
      .clk   (clk),
      .we    (buf_we),
      .waddr (buf_waddr),
      .wdata (buf_wdata),
      .raddr (buf_raddr),
      .rdata (buf_rdata)
   );

   shake_feeder u_feeder (
      .clk             (clk),
      .rst             (rst),
      .msg_ready       (msg_ready),
      .buf_raddr       (buf_raddr),
      .buf_rdata       (buf_rdata),
      .shake_din_valid (shake_din_valid),
      .shake_din       (shake_din),
      .shake_din_ready (shake_din_ready),
      .stream_done     (stream_done)
   );

   key_store u_key_store (
      .clk              (clk),
      .rst              (rst),
      .stream_done      (stream_done),
      .shake_dout_ready (shake_dout_ready),
      .shake_dout_valid (shake_dout_valid),
      .shake_dout       (shake_dout),
      .k_rd             (k_rd),
      .k_addr           (k_addr),
      .k_word           (k_word),
      .done             (done)
   );

endmodule

// File: src/key_store.sv
`timescale 1ns/1ps
`include "kem_config.svh"

module key_store (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   stream_done,
   output logic                   shake_dout_ready,
   input  logic                   shake_dout_valid,
   input  kem_pkg::kem_word_t     shake_dout,
   input  logic                   k_rd,
   input  logic [`KEM_KEY_AW-1:0] k_addr,
   output kem_pkg::kem_word_t     k_word,
   output logic                   done
);

   import kem_pkg::*;

   kem_word_t key_mem [`KEM_KEY_WORDS];

   logic                   armed;
   logic [`KEM_KEY_AW-1:0] cnt;
   logic                   capture;
   logic                   last_cap;

   // ready comes up with the stream strobe, then armed holds it
   assign shake_dout_ready = armed || stream_done;
   assign capture          = shake_dout_valid && shake_dout_ready;
   assign last_cap         = capture && (cnt == `KEM_KEY_AW'(`KEM_KEY_WORDS - 1));

   always_ff @(posedge clk) begin
      if (rst) begin
         armed <= 1'b0;
         cnt   <= '0;
         done  <= 1'b0;
      end else begin
         done <= last_cap;
         if (stream_done) begin
            armed <= 1'b1;
         end
         // wraps back to zero after the eighth word
         if (capture) begin
            cnt <= cnt + 1'b1;
         end
         if (last_cap) begin
            armed <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (capture) begin
         key_mem[cnt] <= byte_rev(shake_dout);
      end
      if (k_rd) begin
         k_word <= key_mem[k_addr];
      end
   end

endmodule

// File: src/shake_feeder.sv
`timescale 1ns/1ps
`include "kem_config.svh"

module shake_feeder (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   msg_ready,
   output logic [`KEM_BUF_AW-1:0] buf_raddr,
   input  kem_pkg::kem_word_t     buf_rdata,
   output logic                   shake_din_valid,
   output kem_pkg::kem_word_t     shake_din,
   input  logic                   shake_din_ready,
   output logic                   stream_done
);

   import kem_pkg::*;

   feeder_state_e state;

   logic [`KEM_BUF_AW-1:0] ptr;
   logic [`KEM_BUF_AW-1:0] ptr_nxt;
   // word index inside the current block, up to 33
   logic [5:0]             cnt;
   logic                   fire;
   logic                   last_word;
   logic                   last_grp;
   logic                   grp_end;

   assign shake_din_valid = (state == fd_start_cmd) || (state == fd_block_cmd) ||
                            (state == fd_data);
   assign fire            = shake_din_valid && shake_din_ready;
   assign stream_done     = (state == fd_wait_out);

   assign last_word = (ptr == `KEM_BUF_AW'(`KEM_MSG_WORDS - 1));
   assign grp_end   = (cnt == 6'(`KEM_RATE_WORDS - 1));

   // only looked at in block_cmd, where ptr is the first word of the group
   assign last_grp = (ptr >= `KEM_BUF_AW'(`KEM_MSG_WORDS - `KEM_RATE_WORDS));

   // address runs one ahead on a transfer so rdata is ready next cycle
   assign ptr_nxt   = ((state == fd_data) && fire && !last_word) ? ptr + 1'b1 : ptr;
   assign buf_raddr = ptr_nxt;

   always_comb begin
      case (state)
         fd_start_cmd: shake_din = `KEM_SHAKE_START;
         fd_block_cmd: shake_din = last_grp ? `KEM_SHAKE_LAST : `KEM_SHAKE_FULL;
         fd_data:      shake_din = buf_rdata;
         default:      shake_din = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= fd_idle;
         ptr   <= '0;
         cnt   <= '0;
      end else begin
         ptr <= ptr_nxt;

         case (state)
            fd_idle: begin
               if (msg_ready) begin
                  state <= fd_start_cmd;
                  ptr   <= '0;
               end
            end

            fd_start_cmd: begin
               if (fire) begin
                  state <= fd_block_cmd;
               end
            end

            fd_block_cmd: begin
               if (fire) begin
                  state <= fd_data;
                  cnt   <= '0;
               end
            end

            fd_data: begin
               if (fire) begin
                  if (last_word) begin
                     state <= fd_wait_out;
                  end else if (grp_end) begin
                     state <= fd_block_cmd;
                  end else begin
                     cnt <= cnt + 1'b1;
                  end
               end
            end

            fd_wait_out: begin
               state <= fd_idle;
            end

            default: begin
               state <= fd_idle;
            end
         endcase
      end
   end

endmodule

// File: src/hash_msg_packer.sv
`timescale 1ns/1ps
`include "kem_config.svh"

module hash_msg_packer (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   start,
   output logic                   e_rd,
   output logic [`KEM_E_AW-1:0]   e_addr,
   input  kem_pkg::kem_word_t     e_word,
   output logic                   c_rd,
   output logic [`KEM_C_AW-1:0]   c_addr,
   input  kem_pkg::kem_word_t     c_word,
   output logic                   buf_we,
   output logic [`KEM_BUF_AW-1:0] buf_waddr,
   output kem_pkg::kem_word_t     buf_wdata,
   output logic                   msg_ready
);

   import kem_pkg::*;

   packer_state_e state;

   logic       rd_valid;
   logic       rd_from_c;
   logic [7:0] carry;
   logic       flush_wr;
   kem_word_t  in_word;
   kem_word_t  rev_word;

   assign e_rd      = (state == pk_read_e);
   assign c_rd      = (state == pk_read_c);
   assign msg_ready = (state == pk_done);

   // memory word returned from the previous cycle's read
   assign in_word  = rd_from_c ? c_word : e_word;
   assign rev_word = byte_rev(in_word);

   // last leftover byte goes out once the read pipe is empty
   assign flush_wr = (state == pk_flush) && !rd_valid;

   assign buf_we    = rd_valid || flush_wr;
   assign buf_wdata = rd_valid ? {rev_word[23:0], carry} : {24'h000000, carry};

   // one byte offset from the prefix, so one byte carries over
   always_ff @(posedge clk) begin
      if ((state == pk_idle) && start) begin
         carry <= 8'h01;
      end else if (rd_valid) begin
         carry <= rev_word[31:24];
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state     <= pk_idle;
         e_addr    <= '0;
         c_addr    <= '0;
         buf_waddr <= '0;
         rd_valid  <= 1'b0;
         rd_from_c <= 1'b0;
      end else begin
         rd_valid  <= e_rd || c_rd;
         rd_from_c <= c_rd;

         if (buf_we) begin
            buf_waddr <= buf_waddr + 1'b1;
         end

         case (state)
            pk_idle: begin
               if (start) begin
                  state     <= pk_read_e;
                  e_addr    <= '0;
                  c_addr    <= '0;
                  buf_waddr <= '0;
               end
            end

            pk_read_e: begin
               if (e_addr == `KEM_E_AW'(`KEM_E_WORDS - 1)) begin
                  state <= pk_read_c;
               end else begin
                  e_addr <= e_addr + 1'b1;
               end
            end

            pk_read_c: begin
               if (c_addr == `KEM_C_AW'(`KEM_C_WORDS - 1)) begin
                  state <= pk_flush;
               end else begin
                  c_addr <= c_addr + 1'b1;
               end
            end

            // first cycle still writes the last ciphertext word
            pk_flush: begin
               if (!rd_valid) begin
                  state <= pk_done;
               end
            end

            pk_done: begin
               state <= pk_idle;
            end

            default: begin
               state <= pk_idle;
            end
         endcase
      end
   end

endmodule

// File: src/hash_buffer_ram.sv
`timescale 1ns/1ps
`include "kem_config.svh"

module hash_buffer_ram (
   input  logic                   clk,
   input  logic                   we,
   input  logic [`KEM_BUF_AW-1:0] waddr,
   input  kem_pkg::kem_word_t     wdata,
   input  logic [`KEM_BUF_AW-1:0] raddr,
   output kem_pkg::kem_word_t     rdata
);

   import kem_pkg::*;

   // packed hash message, one word per address
   kem_word_t mem [`KEM_MSG_WORDS];

   always_ff @(posedge clk) begin
      if (we) begin
         mem[waddr] <= wdata;
      end
      rdata <= mem[raddr];
   end

endmodule

// File: src/kem_pkg.sv
package kem_pkg;

   typedef logic [31:0] kem_word_t;

   typedef enum logic [2:0] {
      pk_idle,
      pk_read_e,
      pk_read_c,
      pk_flush,
      pk_done
   } packer_state_e;

   typedef enum logic [2:0] {
      fd_idle,
      fd_start_cmd,
      fd_block_cmd,
      fd_data,
      fd_wait_out
   } feeder_state_e;

   function automatic kem_word_t byte_rev(input kem_word_t w);
      return {w[7:0], w[15:8], w[23:16], w[31:24]};
   endfunction

endpackage

// File: include/kem_config.svh
`ifndef KEM_CONFIG_SVH
`define KEM_CONFIG_SVH

// parameter set 1 sizes, counted in 32-bit words
`define KEM_E_WORDS     109
`define KEM_C_WORDS     24
`define KEM_MSG_BYTES   533
`define KEM_MSG_WORDS   ((`KEM_MSG_BYTES + 3) / 4)
`define KEM_RATE_WORDS  34
`define KEM_KEY_WORDS   8

// address widths of the word memories
`define KEM_E_AW        7
`define KEM_C_AW        5
`define KEM_KEY_AW      3
`define KEM_BUF_AW      8

// shake256 with 256 output bits
`define KEM_SHAKE_START 32'h4000_0100
// full 1088-bit block
`define KEM_SHAKE_FULL  32'h0000_0440
// final block holds 1000 bits
`define KEM_SHAKE_LAST  32'h8000_03e8

`endif
